// File: rtl/mips_pkg.sv
`default_nettype none

package mips_pkg;

    // --------------------------------------------------
    // Instruction word, seen in three formats
    // --------------------------------------------------
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] func;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] index26;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    // --------------------------------------------------
    // Encodings
    // --------------------------------------------------
    localparam logic [5:0] OP_SPECIAL = 6'b000000, OP_REGIMM = 6'b000001,
                           OP_J       = 6'b000010, OP_JAL    = 6'b000011,
                           OP_BEQ     = 6'b000100, OP_BNE    = 6'b000101,
                           OP_BLEZ    = 6'b000110, OP_BGTZ   = 6'b000111;
    localparam logic [5:0] OP_ADDI    = 6'b001000, OP_ADDIU  = 6'b001001,
                           OP_SLTI    = 6'b001010, OP_SLTIU  = 6'b001011,
                           OP_ANDI    = 6'b001100, OP_ORI    = 6'b001101,
                           OP_XORI    = 6'b001110, OP_LUI    = 6'b001111;
    localparam logic [5:0] OP_LB      = 6'b100000, OP_LH     = 6'b100001,
                           OP_LWL     = 6'b100010, OP_LW     = 6'b100011,
                           OP_LBU     = 6'b100100, OP_LHU    = 6'b100101,
                           OP_LWR     = 6'b100110;
    localparam logic [5:0] OP_SB      = 6'b101000, OP_SH     = 6'b101001,
                           OP_SWL     = 6'b101010, OP_SW     = 6'b101011,
                           OP_SWR     = 6'b101110;

    localparam logic [5:0] FN_SLL  = 6'b000000, FN_SRL   = 6'b000010, FN_SRA  = 6'b000011,
                           FN_SLLV = 6'b000100, FN_SRLV  = 6'b000110, FN_SRAV = 6'b000111,
                           FN_JR   = 6'b001000, FN_JALR  = 6'b001001;
    localparam logic [5:0] FN_MFHI = 6'b010000, FN_MTHI  = 6'b010001,
                           FN_MFLO = 6'b010010, FN_MTLO  = 6'b010011,
                           FN_MULT = 6'b011000, FN_MULTU = 6'b011001,
                           FN_DIV  = 6'b011010, FN_DIVU  = 6'b011011;
    localparam logic [5:0] FN_ADD  = 6'b100000, FN_ADDU  = 6'b100001,
                           FN_SUB  = 6'b100010, FN_SUBU  = 6'b100011,
                           FN_AND  = 6'b100100, FN_OR    = 6'b100101,
                           FN_XOR  = 6'b100110, FN_NOR   = 6'b100111,
                           FN_SLT  = 6'b101010, FN_SLTU  = 6'b101011;

    // REGIMM branches are told apart by the rt field
    localparam logic [4:0] RT_BLTZ   = 5'b00000, RT_BGEZ   = 5'b00001,
                           RT_BLTZAL = 5'b10000, RT_BGEZAL = 5'b10001;

    // Bit positions in the one-hot ALU operation word
    localparam int ALU_ADD = 0, ALU_SUB = 1, ALU_SLT = 2, ALU_SLTU = 3;
    localparam int ALU_SLL = 4, ALU_SRL = 5, ALU_SRA = 6, ALU_LUI = 7;
    localparam int ALU_OR  = 8, ALU_XOR = 9, ALU_AND = 10, ALU_NOR = 11;
    localparam int ALU_OP_W = 12;

    // --------------------------------------------------
    // Control and stage records
    // --------------------------------------------------
    typedef struct packed {
        logic is_next;
        logic is_branch;
        logic is_jal;
        logic is_jr;
    } pc_sel_t;

    typedef struct packed {
        logic                imm_sign_extend;
        logic [ALU_OP_W-1:0] alu_op;
        logic                a_pc, a_rs, a_shamt;
        logic                b_rt, b_imm, b_8;
        logic                res_alu, res_lo, res_hi;
        logic                is_mult, is_multu, is_div, is_divu, lo_wen, hi_wen;
        logic                mem_w, mem_b, mem_h, mem_bu, mem_hu, mem_wl, mem_wr;
        logic                mem_wen;
        logic                reg_write, wr_rd, wr_rt, wr_31;
        logic                wr_alu, wr_mem;
        pc_sel_t             pc_sel;
    } ctrl_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] result;
        logic [31:0] store_data;  // rt value for stores
        logic [4:0]  wr_addr;
        logic        reg_write, wr_mem;
        logic        mem_w, mem_b, mem_h, mem_bu, mem_hu, mem_wl, mem_wr;
        logic        mem_wen;
        logic        res_alu, res_lo, res_hi;
        logic        is_mult, is_multu, is_div, is_divu, lo_wen, hi_wen;
    } ex_out_t;

endpackage

`default_nettype wire

// File: rtl/branch_ctrl.sv
`default_nettype none

module branch_ctrl (
    input  logic             en,
    input  mips_pkg::instr_u instr,
    input  logic [31:0]      rs_data,
    input  logic [31:0]      rt_data,
    output logic             take,
    output logic             link
);
    wire [5:0] op   = instr.i_fmt.opcode;
    wire [4:0] rt   = instr.i_fmt.rt;
    wire       eq   = rs_data == rt_data;
    wire       neg  = rs_data[31];
    wire       zero = rs_data == 32'd0;

    logic cond;

    always_comb begin
        case (op)
            mips_pkg::OP_BEQ:  cond = eq;
            mips_pkg::OP_BNE:  cond = ~eq;
            mips_pkg::OP_BLEZ: cond = neg | zero;
            mips_pkg::OP_BGTZ: cond = ~neg & ~zero;
            mips_pkg::OP_REGIMM: begin
                case (rt)
                    mips_pkg::RT_BLTZ, mips_pkg::RT_BLTZAL: cond = neg;
                    mips_pkg::RT_BGEZ, mips_pkg::RT_BGEZAL: cond = ~neg;
                    default: cond = 1'b0;  // Unsupported REGIMM
                endcase
            end
            default: cond = 1'b0;
        endcase
    end

    assign take = en & cond;
    // Link forms write r31 even when not taken
    assign link = (op == mips_pkg::OP_REGIMM) &
                  (rt == mips_pkg::RT_BLTZAL | rt == mips_pkg::RT_BGEZAL);

endmodule

`default_nettype wire

// File: rtl/control.sv
`default_nettype none

module control (
    input  logic             valid,
    input  mips_pkg::instr_u instr,
    input  logic [31:0]      rs_data,
    input  logic [31:0]      rt_data,
    output mips_pkg::ctrl_t  ctrl
);
    wire [5:0] op   = instr.r_fmt.opcode;
    wire [5:0] func = instr.r_fmt.func;
    wire       is_r = op == mips_pkg::OP_SPECIAL;

    // --------------------------------------------------
    // Opcode matches
    // --------------------------------------------------
    wire is_addi  = op == mips_pkg::OP_ADDI;
    wire is_addiu = op == mips_pkg::OP_ADDIU;
    wire is_slti  = op == mips_pkg::OP_SLTI;
    wire is_sltiu = op == mips_pkg::OP_SLTIU;
    wire is_andi  = op == mips_pkg::OP_ANDI;
    wire is_ori   = op == mips_pkg::OP_ORI;
    wire is_xori  = op == mips_pkg::OP_XORI;
    wire is_lui   = op == mips_pkg::OP_LUI;
    wire is_j     = op == mips_pkg::OP_J;
    wire is_jal   = op == mips_pkg::OP_JAL;
    wire is_lb    = op == mips_pkg::OP_LB;
    wire is_lh    = op == mips_pkg::OP_LH;
    wire is_lwl   = op == mips_pkg::OP_LWL;
    wire is_lw    = op == mips_pkg::OP_LW;
    wire is_lbu   = op == mips_pkg::OP_LBU;
    wire is_lhu   = op == mips_pkg::OP_LHU;
    wire is_lwr   = op == mips_pkg::OP_LWR;
    wire is_sb    = op == mips_pkg::OP_SB;
    wire is_sh    = op == mips_pkg::OP_SH;
    wire is_swl   = op == mips_pkg::OP_SWL;
    wire is_sw    = op == mips_pkg::OP_SW;
    wire is_swr   = op == mips_pkg::OP_SWR;

    // Function matches, already qualified with R-type
    wire fn_sll   = is_r & (func == mips_pkg::FN_SLL);
    wire fn_srl   = is_r & (func == mips_pkg::FN_SRL);
    wire fn_sra   = is_r & (func == mips_pkg::FN_SRA);
    wire fn_sllv  = is_r & (func == mips_pkg::FN_SLLV);
    wire fn_srlv  = is_r & (func == mips_pkg::FN_SRLV);
    wire fn_srav  = is_r & (func == mips_pkg::FN_SRAV);
    wire fn_jr    = is_r & (func == mips_pkg::FN_JR);
    wire fn_jalr  = is_r & (func == mips_pkg::FN_JALR);
    wire fn_mfhi  = is_r & (func == mips_pkg::FN_MFHI);
    wire fn_mthi  = is_r & (func == mips_pkg::FN_MTHI);
    wire fn_mflo  = is_r & (func == mips_pkg::FN_MFLO);
    wire fn_mtlo  = is_r & (func == mips_pkg::FN_MTLO);
    wire fn_mult  = is_r & (func == mips_pkg::FN_MULT);
    wire fn_multu = is_r & (func == mips_pkg::FN_MULTU);
    wire fn_div   = is_r & (func == mips_pkg::FN_DIV);
    wire fn_divu  = is_r & (func == mips_pkg::FN_DIVU);
    wire fn_add   = is_r & (func == mips_pkg::FN_ADD);
    wire fn_addu  = is_r & (func == mips_pkg::FN_ADDU);
    wire fn_sub   = is_r & (func == mips_pkg::FN_SUB);
    wire fn_subu  = is_r & (func == mips_pkg::FN_SUBU);
    wire fn_and   = is_r & (func == mips_pkg::FN_AND);
    wire fn_or    = is_r & (func == mips_pkg::FN_OR);
    wire fn_xor   = is_r & (func == mips_pkg::FN_XOR);
    wire fn_nor   = is_r & (func == mips_pkg::FN_NOR);
    wire fn_slt   = is_r & (func == mips_pkg::FN_SLT);
    wire fn_sltu  = is_r & (func == mips_pkg::FN_SLTU);

    wire is_load   = |{is_lb, is_lh, is_lwl, is_lw, is_lbu, is_lhu, is_lwr};
    wire is_store  = |{is_sb, is_sh, is_swl, is_sw, is_swr};
    wire imm_arith = |{is_addi, is_addiu, is_slti, is_sltiu, is_andi, is_ori, is_xori, is_lui};

    wire branch_link;
    wire link    = is_jal | branch_link | fn_jalr;  // Writes pc+8
    wire link_31 = is_jal | branch_link;

    branch_ctrl u_branch (
        .en      (valid),
        .instr   (instr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .take    (ctrl.pc_sel.is_branch),
        .link    (branch_link)
    );

    // --------------------------------------------------
    // Next PC selects
    // --------------------------------------------------
    assign ctrl.pc_sel.is_jal = valid & (is_j | is_jal);
    assign ctrl.pc_sel.is_jr  = valid & (fn_jr | fn_jalr);
    assign ctrl.pc_sel.is_next =
        ~ctrl.pc_sel.is_branch & ~ctrl.pc_sel.is_jal & ~ctrl.pc_sel.is_jr;

    // Operand selects
    assign ctrl.imm_sign_extend = ~(is_andi | is_ori | is_xori);
    assign ctrl.a_pc    = link;
    assign ctrl.a_shamt = fn_sll | fn_srl | fn_sra;  // Constant shifts
    assign ctrl.a_rs    = ~ctrl.a_pc & ~ctrl.a_shamt;
    assign ctrl.b_rt    = is_r & ~link;
    assign ctrl.b_imm   = is_load | is_store | imm_arith;
    assign ctrl.b_8     = link;

    assign ctrl.alu_op[mips_pkg::ALU_ADD] =
        fn_add | fn_addu | is_addi | is_addiu | is_load | is_store | link;
    assign ctrl.alu_op[mips_pkg::ALU_SUB]  = fn_sub | fn_subu;
    assign ctrl.alu_op[mips_pkg::ALU_SLT]  = fn_slt | is_slti;
    assign ctrl.alu_op[mips_pkg::ALU_SLTU] = fn_sltu | is_sltiu;
    assign ctrl.alu_op[mips_pkg::ALU_SLL]  = fn_sll | fn_sllv;
    assign ctrl.alu_op[mips_pkg::ALU_SRL]  = fn_srl | fn_srlv;
    assign ctrl.alu_op[mips_pkg::ALU_SRA]  = fn_sra | fn_srav;
    assign ctrl.alu_op[mips_pkg::ALU_LUI]  = is_lui;
    assign ctrl.alu_op[mips_pkg::ALU_OR]   = fn_or | is_ori;
    assign ctrl.alu_op[mips_pkg::ALU_XOR]  = fn_xor | is_xori;
    assign ctrl.alu_op[mips_pkg::ALU_AND]  = fn_and | is_andi;
    assign ctrl.alu_op[mips_pkg::ALU_NOR]  = fn_nor;

    // --------------------------------------------------
    // Result, HI/LO and memory
    // --------------------------------------------------
    assign ctrl.res_hi  = fn_mfhi;
    assign ctrl.res_lo  = fn_mflo;
    assign ctrl.res_alu = ~fn_mfhi & ~fn_mflo;

    assign ctrl.is_mult  = fn_mult;
    assign ctrl.is_multu = fn_multu;
    assign ctrl.is_div   = fn_div;
    assign ctrl.is_divu  = fn_divu;
    assign ctrl.lo_wen   = fn_mtlo;
    assign ctrl.hi_wen   = fn_mthi;

    assign ctrl.mem_w   = |{is_lw, is_lwl, is_lwr, is_sw};
    assign ctrl.mem_b   = is_lb | is_sb;
    assign ctrl.mem_h   = is_lh | is_sh;
    assign ctrl.mem_bu  = is_lbu;
    assign ctrl.mem_hu  = is_lhu;
    assign ctrl.mem_wl  = is_lwl | is_swl;
    assign ctrl.mem_wr  = is_lwr | is_swr;
    assign ctrl.mem_wen = is_store;

    // Register write and its address
    assign ctrl.reg_write = is_r | is_load | link | imm_arith;
    assign ctrl.wr_rd     = is_r;
    assign ctrl.wr_31     = link_31;
    assign ctrl.wr_rt     = ~ctrl.wr_rd & ~ctrl.wr_31;
    assign ctrl.wr_mem    = is_load;
    assign ctrl.wr_alu    = ~is_load;

endmodule

`default_nettype wire

// File: rtl/next_pc.sv
`default_nettype none

module next_pc (
    input  logic              [31:0] pc,
    input  mips_pkg::instr_u         instr,
    input  logic              [31:0] rs_data,
    input  mips_pkg::pc_sel_t        pc_sel,
    output logic              [31:0] pc_next
);
    wire [15:0] imm16    = instr.i_fmt.imm16;
    wire [31:0] pc_plus4 = pc + 32'd4;

    // Word offset relative to the delay slot
    wire [31:0] br_target = pc_plus4 + {{14{imm16[15]}}, imm16, 2'b00};
    wire [31:0] j_target  = {pc_plus4[31:28], instr.j_fmt.index26, 2'b00};

    assign pc_next = ({32{pc_sel.is_next}}   & pc_plus4)  |
                     ({32{pc_sel.is_branch}} & br_target) |
                     ({32{pc_sel.is_jal}}    & j_target)  |
                     ({32{pc_sel.is_jr}}     & rs_data);

endmodule

`default_nettype wire

// File: rtl/alu.sv
`default_nettype none

module alu (
    input  logic [mips_pkg::ALU_OP_W-1:0] op,
    input  logic [31:0]                   a,
    input  logic [31:0]                   b,
    output logic [31:0]                   y
);
    wire [4:0] sa = a[4:0];  // Shift amount

    logic [31:0] res [mips_pkg::ALU_OP_W];

    always_comb begin
        res[mips_pkg::ALU_ADD]  = a + b;
        res[mips_pkg::ALU_SUB]  = a - b;
        res[mips_pkg::ALU_SLT]  = {31'd0, $signed(a) < $signed(b)};
        res[mips_pkg::ALU_SLTU] = {31'd0, a < b};
        res[mips_pkg::ALU_SLL]  = b << sa;
        res[mips_pkg::ALU_SRL]  = b >> sa;
        res[mips_pkg::ALU_SRA]  = $signed(b) >>> sa;
        res[mips_pkg::ALU_LUI]  = {b[15:0], 16'd0};
        res[mips_pkg::ALU_OR]   = a | b;
        res[mips_pkg::ALU_XOR]  = a ^ b;
        res[mips_pkg::ALU_AND]  = a & b;
        res[mips_pkg::ALU_NOR]  = ~(a | b);
    end

    // One-hot op, so the masked results simply OR together
    always_comb begin
        y = '0;
        for (int i = 0; i < mips_pkg::ALU_OP_W; i++) begin
            y = y | ({32{op[i]}} & res[i]);
        end
    end

endmodule

`default_nettype wire

// File: rtl/execute.sv
`default_nettype none

module execute (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              valid,
    input  logic [31:0]       pc,
    input  mips_pkg::instr_u  instr,
    input  logic [31:0]       rs_data,
    input  logic [31:0]       rt_data,
    input  mips_pkg::ctrl_t   ctrl,
    output mips_pkg::ex_out_t ex_out
);
    wire [15:0] imm16 = instr.i_fmt.imm16;

    logic [31:0] imm_ext;
    logic [31:0] alu_a;
    logic [31:0] alu_b;
    logic [31:0] alu_y;
    logic [4:0]  wr_addr;

    // --------------------------------------------------
    // Operand selection
    // --------------------------------------------------
    assign imm_ext = ctrl.imm_sign_extend ? {{16{imm16[15]}}, imm16} : {16'd0, imm16};

    assign alu_a = ({32{ctrl.a_pc}}    & pc)      |
                   ({32{ctrl.a_rs}}    & rs_data) |
                   ({32{ctrl.a_shamt}} & {27'd0, instr.r_fmt.shamt});

    assign alu_b = ({32{ctrl.b_rt}}  & rt_data) |
                   ({32{ctrl.b_imm}} & imm_ext) |
                   ({32{ctrl.b_8}}   & 32'd8);  // Link return address

    assign wr_addr = ({5{ctrl.wr_rd}} & instr.r_fmt.rd) |
                     ({5{ctrl.wr_rt}} & instr.i_fmt.rt) |
                     ({5{ctrl.wr_31}} & 5'd31);

    alu u_alu (
        .op (ctrl.alu_op),
        .a  (alu_a),
        .b  (alu_b),
        .y  (alu_y)
    );

    // --------------------------------------------------
    // Stage register
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        ex_out.result     <= alu_y;
        ex_out.store_data <= rt_data;
        ex_out.wr_addr    <= wr_addr;
        ex_out.wr_mem     <= ctrl.wr_mem;
        ex_out.mem_w      <= ctrl.mem_w;
        ex_out.mem_b      <= ctrl.mem_b;
        ex_out.mem_h      <= ctrl.mem_h;
        ex_out.mem_bu     <= ctrl.mem_bu;
        ex_out.mem_hu     <= ctrl.mem_hu;
        ex_out.mem_wl     <= ctrl.mem_wl;
        ex_out.mem_wr     <= ctrl.mem_wr;
        ex_out.res_alu    <= ctrl.res_alu;
        ex_out.res_lo     <= ctrl.res_lo;
        ex_out.res_hi     <= ctrl.res_hi;
        ex_out.is_mult    <= ctrl.is_mult;
        ex_out.is_multu   <= ctrl.is_multu;
        ex_out.is_div     <= ctrl.is_div;
        ex_out.is_divu    <= ctrl.is_divu;
        if (!rst_n) begin
            ex_out.valid     <= 1'b0;
            ex_out.reg_write <= 1'b0;
            ex_out.mem_wen   <= 1'b0;
            ex_out.lo_wen    <= 1'b0;
            ex_out.hi_wen    <= 1'b0;
        end else begin  // Bubbles carry no writes
            ex_out.valid     <= valid;
            ex_out.reg_write <= valid & ctrl.reg_write;
            ex_out.mem_wen   <= valid & ctrl.mem_wen;
            ex_out.lo_wen    <= valid & ctrl.lo_wen;
            ex_out.hi_wen    <= valid & ctrl.hi_wen;
        end
    end

endmodule

`default_nettype wire

// File: rtl/decode_execute.sv
`default_nettype none

module decode_execute (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              valid,
    input  logic [31:0]       pc,
    input  mips_pkg::instr_u  instr,
    input  logic [31:0]       rs_data,
    input  logic [31:0]       rt_data,
    output logic [31:0]       pc_next,
    output mips_pkg::ex_out_t ex_out
);
    mips_pkg::ctrl_t ctrl;

    // --------------------------------------------------
    // Decode, then next PC and execute side by side
    // --------------------------------------------------
    control u_control (
        .valid   (valid),
        .instr   (instr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .ctrl    (ctrl)
    );

    next_pc u_next_pc (
        .pc      (pc),
        .instr   (instr),
        .rs_data (rs_data),
        .pc_sel  (ctrl.pc_sel),
        .pc_next (pc_next)
    );

    execute u_execute (
        .clk     (clk),
        .rst_n   (rst_n),
        .valid   (valid),
        .pc      (pc),
        .instr   (instr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .ctrl    (ctrl),
        .ex_out  (ex_out)
    );

endmodule

`default_nettype wire

// File: bench/ex_checker.sv
`default_nettype none

module ex_checker (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              valid,
    input  logic [31:0]       pc,
    input  mips_pkg::instr_u  instr,
    input  logic [31:0]       rs_data,
    input  logic [31:0]       rt_data,
    input  logic [31:0]       pc_next,
    input  mips_pkg::ex_out_t ex_out,
    output int                errors,
    output int                checks
);
    int err_cnt = 0;
    int chk_cnt = 0;

    mips_pkg::ex_out_t prev_rec;
    string             prev_name;
    logic              prev_rst;
    logic              have_prev = 1'b0;

    assign errors = err_cnt;
    assign checks = chk_cnt;

    task automatic compare(input string test, input string what,
                           input logic [127:0] exp, input logic [127:0] act);
        chk_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("Mismatch %s %s: expected %0h, actual %0h", test, what, exp, act);
        end
    endtask

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic mips_pkg::ex_out_t ref_model(
        input mips_pkg::instr_u ins, input logic [31:0] pc_in, input logic [31:0] rs,
        input logic [31:0] rt, input logic vld, output logic [31:0] exp_pc);
        mips_pkg::ex_out_t r;
        logic [31:0]       sext;
        logic [31:0]       zext;
        logic [31:0]       pc4;
        logic              take;
        logic              jump;
        logic              jump_reg;
        r          = '0;
        take       = 1'b0;
        jump       = 1'b0;
        jump_reg   = 1'b0;
        pc4        = pc_in + 32'd4;
        sext       = {{16{ins.i_fmt.imm16[15]}}, ins.i_fmt.imm16};
        zext       = {16'd0, ins.i_fmt.imm16};
        r.store_data = rt;
        r.res_alu    = 1'b1;
        r.wr_addr    = ins.i_fmt.rt;
        case (ins.r_fmt.opcode)
            mips_pkg::OP_SPECIAL: begin
                r.reg_write = 1'b1;
                r.wr_addr   = ins.r_fmt.rd;
                case (ins.r_fmt.func)
                    mips_pkg::FN_SLL:  r.result = rt << ins.r_fmt.shamt;
                    mips_pkg::FN_SRL:  r.result = rt >> ins.r_fmt.shamt;
                    mips_pkg::FN_SRA:  r.result = $signed(rt) >>> ins.r_fmt.shamt;
                    mips_pkg::FN_SLLV: r.result = rt << rs[4:0];
                    mips_pkg::FN_SRLV: r.result = rt >> rs[4:0];
                    mips_pkg::FN_SRAV: r.result = $signed(rt) >>> rs[4:0];
                    mips_pkg::FN_JR:   jump_reg = 1'b1;
                    mips_pkg::FN_JALR: begin
                        jump_reg = 1'b1;
                        r.result = pc_in + 32'd8;  // Return address into rd
                    end
                    mips_pkg::FN_MFHI: r.res_hi = 1'b1;
                    mips_pkg::FN_MFLO: r.res_lo = 1'b1;
                    mips_pkg::FN_MTHI: r.hi_wen = 1'b1;
                    mips_pkg::FN_MTLO: r.lo_wen = 1'b1;
                    mips_pkg::FN_MULT:  r.is_mult = 1'b1;
                    mips_pkg::FN_MULTU: r.is_multu = 1'b1;
                    mips_pkg::FN_DIV:   r.is_div = 1'b1;
                    mips_pkg::FN_DIVU:  r.is_divu = 1'b1;
                    mips_pkg::FN_ADD, mips_pkg::FN_ADDU: r.result = rs + rt;
                    mips_pkg::FN_SUB, mips_pkg::FN_SUBU: r.result = rs - rt;
                    mips_pkg::FN_AND:  r.result = rs & rt;
                    mips_pkg::FN_OR:   r.result = rs | rt;
                    mips_pkg::FN_XOR:  r.result = rs ^ rt;
                    mips_pkg::FN_NOR:  r.result = ~(rs | rt);
                    mips_pkg::FN_SLT:  r.result = {31'd0, $signed(rs) < $signed(rt)};
                    mips_pkg::FN_SLTU: r.result = {31'd0, rs < rt};
                    default: ;
                endcase
                r.res_alu = ~r.res_hi & ~r.res_lo;
            end
            mips_pkg::OP_REGIMM: begin
                take = ins.i_fmt.rt[0] ? ~rs[31] : rs[31];  // bgez forms vs bltz forms
                if (ins.i_fmt.rt[4]) begin
                    r.reg_write = 1'b1;
                    r.wr_addr   = 5'd31;
                    r.result    = pc_in + 32'd8;
                end
            end
            mips_pkg::OP_J: jump = 1'b1;
            mips_pkg::OP_JAL: begin
                jump        = 1'b1;
                r.reg_write = 1'b1;
                r.wr_addr   = 5'd31;
                r.result    = pc_in + 32'd8;
            end
            mips_pkg::OP_BEQ:  take = rs == rt;
            mips_pkg::OP_BNE:  take = rs != rt;
            mips_pkg::OP_BLEZ: take = $signed(rs) <= 32'sd0;
            mips_pkg::OP_BGTZ: take = $signed(rs) > 32'sd0;
            mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU: r.result = rs + sext;
            mips_pkg::OP_SLTI:  r.result = {31'd0, $signed(rs) < $signed(sext)};
            mips_pkg::OP_SLTIU: r.result = {31'd0, rs < sext};
            mips_pkg::OP_ANDI: r.result = rs & zext;
            mips_pkg::OP_ORI:  r.result = rs | zext;
            mips_pkg::OP_XORI: r.result = rs ^ zext;
            mips_pkg::OP_LUI:  r.result = {ins.i_fmt.imm16, 16'd0};
            mips_pkg::OP_LB, mips_pkg::OP_SB: r.mem_b = 1'b1;
            mips_pkg::OP_LH, mips_pkg::OP_SH: r.mem_h = 1'b1;
            mips_pkg::OP_LW, mips_pkg::OP_SW: r.mem_w = 1'b1;
            mips_pkg::OP_LBU: r.mem_bu = 1'b1;
            mips_pkg::OP_LHU: r.mem_hu = 1'b1;
            mips_pkg::OP_LWL: begin
                r.mem_w  = 1'b1;
                r.mem_wl = 1'b1;
            end
            mips_pkg::OP_LWR: begin
                r.mem_w  = 1'b1;
                r.mem_wr = 1'b1;
            end
            mips_pkg::OP_SWL: r.mem_wl = 1'b1;
            mips_pkg::OP_SWR: r.mem_wr = 1'b1;
            default: ;
        endcase
        if (ins.r_fmt.opcode[5:3] == 3'b001) r.reg_write = 1'b1;  // Immediate ALU ops
        if (ins.r_fmt.opcode[5:4] == 2'b10) r.result = rs + sext;  // Effective address
        if (ins.r_fmt.opcode[5:3] == 3'b100) begin
            r.reg_write = 1'b1;
            r.wr_mem    = 1'b1;
        end
        r.mem_wen = ins.r_fmt.opcode[5:3] == 3'b101;

        r.valid     = vld;
        r.reg_write = r.reg_write & vld;
        r.mem_wen   = r.mem_wen & vld;
        r.lo_wen    = r.lo_wen & vld;
        r.hi_wen    = r.hi_wen & vld;
        if (vld && take) exp_pc = pc4 + {sext[29:0], 2'b00};
        else if (vld && jump) exp_pc = {pc4[31:28], ins.j_fmt.index26, 2'b00};
        else if (vld && jump_reg) exp_pc = rs;
        else exp_pc = pc4;
        return r;
    endfunction

    function automatic string group_name(input mips_pkg::instr_u ins, input logic vld);
        if (!vld) return "bubble";
        if (ins.r_fmt.opcode == mips_pkg::OP_SPECIAL) begin
            if (ins.r_fmt.func[5:1] == 5'b00100) return "jump_reg";
            if (ins.r_fmt.func[5:4] == 2'b01) return "hilo";
            return "alu_reg";
        end
        if (ins.r_fmt.opcode[5:1] == 5'b00001) return "jump";
        if (ins.r_fmt.opcode[5:3] == 3'b000) return "branch";
        if (ins.r_fmt.opcode[5:3] == 3'b001) return "alu_imm";
        if (ins.r_fmt.opcode[5:3] == 3'b100) return "load";
        return "store";
    endfunction

    // --------------------------------------------------
    // Compare at every rising edge
    // --------------------------------------------------
    always @(posedge clk) begin : watch
        mips_pkg::ex_out_t rec;
        logic [31:0]       exp_pc;
        string             name;
        // ex_out still holds what the previous edge registered
        if (have_prev) begin
            if (prev_rst) begin
                compare("reset", "write enables", 5'b0,
                        {ex_out.valid, ex_out.reg_write, ex_out.mem_wen,
                         ex_out.lo_wen, ex_out.hi_wen});
            end else if (!prev_rec.valid) begin
                compare(prev_name, "write enables", 5'b0,
                        {ex_out.valid, ex_out.reg_write, ex_out.mem_wen,
                         ex_out.lo_wen, ex_out.hi_wen});
            end else begin
                compare(prev_name, "ex_out", prev_rec, ex_out);
            end
        end
        rec  = ref_model(instr, pc, rs_data, rt_data, valid, exp_pc);
        name = group_name(instr, valid);
        if (rst_n) compare(name, "pc_next", exp_pc, pc_next);
        prev_rec  = rec;
        prev_name = name;
        prev_rst  = ~rst_n;
        have_prev = 1'b1;
    end

endmodule

`default_nettype wire

// File: bench/tb_decode_execute.sv
`default_nettype none

module tb_decode_execute;

    localparam int NUM_INSTR = 400;

    logic              clk;
    logic              rst_n;
    logic              valid;
    logic [31:0]       pc;
    mips_pkg::instr_u  instr;
    logic [31:0]       rs_data;
    logic [31:0]       rt_data;
    logic [31:0]       pc_next;
    mips_pkg::ex_out_t ex_out;
    int                errors;
    int                checks;

    logic [5:0] op_list [0:26];
    logic [5:0] fn_list [0:25];
    logic [4:0] regimm_list [0:3];

    decode_execute dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .valid   (valid),
        .pc      (pc),
        .instr   (instr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .pc_next (pc_next),
        .ex_out  (ex_out)
    );

    ex_checker u_checker (
        .clk     (clk),
        .rst_n   (rst_n),
        .valid   (valid),
        .pc      (pc),
        .instr   (instr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .pc_next (pc_next),
        .ex_out  (ex_out),
        .errors  (errors),
        .checks  (checks)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    function automatic mips_pkg::instr_u random_instr();
        mips_pkg::instr_u ins;
        ins = $urandom();
        if ($urandom_range(2, 0) == 0) begin  // R-type about a third of the time
            ins.r_fmt.opcode = mips_pkg::OP_SPECIAL;
            ins.r_fmt.func   = fn_list[$urandom_range(25, 0)];
        end else begin
            ins.r_fmt.opcode = op_list[$urandom_range(26, 0)];
            if (ins.r_fmt.opcode == mips_pkg::OP_REGIMM)
                ins.i_fmt.rt = regimm_list[$urandom_range(3, 0)];
        end
        return ins;
    endfunction

    task automatic drive_cycle();
        valid   = $urandom_range(4, 0) != 0;
        pc      = $urandom() & 32'hffff_fffc;
        instr   = random_instr();
        rs_data = $urandom();
        case ($urandom_range(3, 0))
            0: rt_data = rs_data;  // Lets beq and bne go both ways
            1: begin
                rs_data = 32'd0;
                rt_data = $urandom();
            end
            default: rt_data = $urandom();
        endcase
    endtask

    initial begin
        #((NUM_INSTR + 20) * 10);
        $display("Run timed out after %0d cycles", NUM_INSTR + 20);
        $display("Verification failed");
        $finish;
    end

    initial begin
        void'($urandom(44));
        op_list = '{mips_pkg::OP_REGIMM, mips_pkg::OP_J, mips_pkg::OP_JAL, mips_pkg::OP_BEQ,
                    mips_pkg::OP_BNE, mips_pkg::OP_BLEZ, mips_pkg::OP_BGTZ, mips_pkg::OP_ADDI,
                    mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU, mips_pkg::OP_ANDI,
                    mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LUI, mips_pkg::OP_LB,
                    mips_pkg::OP_LH, mips_pkg::OP_LWL, mips_pkg::OP_LW, mips_pkg::OP_LBU,
                    mips_pkg::OP_LHU, mips_pkg::OP_LWR, mips_pkg::OP_SB, mips_pkg::OP_SH,
                    mips_pkg::OP_SWL, mips_pkg::OP_SW, mips_pkg::OP_SWR};
        fn_list = '{mips_pkg::FN_SLL, mips_pkg::FN_SRL, mips_pkg::FN_SRA, mips_pkg::FN_SLLV,
                    mips_pkg::FN_SRLV, mips_pkg::FN_SRAV, mips_pkg::FN_JR, mips_pkg::FN_JALR,
                    mips_pkg::FN_MFHI, mips_pkg::FN_MTHI, mips_pkg::FN_MFLO, mips_pkg::FN_MTLO,
                    mips_pkg::FN_MULT, mips_pkg::FN_MULTU, mips_pkg::FN_DIV, mips_pkg::FN_DIVU,
                    mips_pkg::FN_ADD, mips_pkg::FN_ADDU, mips_pkg::FN_SUB, mips_pkg::FN_SUBU,
                    mips_pkg::FN_AND, mips_pkg::FN_OR, mips_pkg::FN_XOR, mips_pkg::FN_NOR,
                    mips_pkg::FN_SLT, mips_pkg::FN_SLTU};
        regimm_list = '{mips_pkg::RT_BLTZ, mips_pkg::RT_BGEZ,
                        mips_pkg::RT_BLTZAL, mips_pkg::RT_BGEZAL};
        rst_n   = 1'b0;
        valid   = 1'b0;
        pc      = 32'd0;
        instr   = '0;
        rs_data = 32'd0;
        rt_data = 32'd0;
        // Live instructions while reset is held
        repeat (7) begin
            @(negedge clk);
            drive_cycle();
            valid = 1'b1;
        end
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < NUM_INSTR; i++) begin
            drive_cycle();
            @(negedge clk);
        end
        valid = 1'b0;
        repeat (2) @(negedge clk);  // Drain the last record
        $display("Closing report: %0d checks, %0d errors", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: decode_execute.f
rtl/mips_pkg.sv
rtl/branch_ctrl.sv
rtl/control.sv
rtl/next_pc.sv
rtl/alu.sv
rtl/execute.sv
rtl/decode_execute.sv
bench/ex_checker.sv
bench/tb_decode_execute.sv

// File: Bender.yml
package:
  name: decode_execute

sources:
  - rtl/mips_pkg.sv
  - rtl/branch_ctrl.sv
  - rtl/control.sv
  - rtl/next_pc.sv
  - rtl/alu.sv
  - rtl/execute.sv
  - rtl/decode_execute.sv
  - target: test
    files:
      - bench/ex_checker.sv
      - bench/tb_decode_execute.sv
